//--- design/vm_pkg.sv
package vm_pkg;

  //////////////////////////////
  // widths and depths
  //////////////////////////////

  localparam int word_w      = 16;
  localparam int byte_w      = 8;
  localparam int code_depth  = 256;
  localparam int var_depth   = 256;
  localparam int stack_depth = 256;

  //////////////////////////////
  // opcodes kept from the VM
  //////////////////////////////

  localparam logic [byte_w-1:0] op_mov_const   = 8'h00;
  localparam logic [byte_w-1:0] op_mov         = 8'h01;
  localparam logic [byte_w-1:0] op_add         = 8'h02;
  localparam logic [byte_w-1:0] op_add_const   = 8'h03;
  localparam logic [byte_w-1:0] op_call        = 8'h04;
  localparam logic [byte_w-1:0] op_ret         = 8'h05;
  localparam logic [byte_w-1:0] op_jmp         = 8'h07;
  localparam logic [byte_w-1:0] op_djnz        = 8'h09;
  localparam logic [byte_w-1:0] op_cond_jmp    = 8'h0A;
  localparam logic [byte_w-1:0] op_kill_thread = 8'h11;
  localparam logic [byte_w-1:0] op_sub         = 8'h13;
  localparam logic [byte_w-1:0] op_and         = 8'h14;
  localparam logic [byte_w-1:0] op_or          = 8'h15;
  localparam logic [byte_w-1:0] op_shl         = 8'h16;
  localparam logic [byte_w-1:0] op_shr         = 8'h17;

  // condJmp subop layout, low three bits carry the condition
  localparam int subop_var_bit  = 7;
  localparam int subop_wide_bit = 6;

  typedef enum logic [2:0] {
    pass_b, add, sub, and_op, or_op, shl, shr, dec
  } alu_op_t;

  // codes 6 and 7 have no name and never branch
  typedef enum logic [2:0] {
    jz, jnz, jg, jge, jl, jle
  } cond_t;

  //////////////////////////////
  // port bundles
  //////////////////////////////

  typedef struct packed {
    logic              en;
    logic [byte_w-1:0] addr;
    logic [byte_w-1:0] data;
  } prog_wr_t;

  typedef struct packed {
    logic              req;
    logic [word_w-1:0] start_pc;
  } run_cmd_t;

  typedef struct packed {
    alu_op_t           op;
    logic [word_w-1:0] a;
    logic [word_w-1:0] b;
  } alu_req_t;

  typedef struct packed {
    logic              is_djnz;
    cond_t             cond;
    logic [word_w-1:0] lhs;
    logic [word_w-1:0] rhs;
  } cmp_req_t;

  typedef struct packed {
    logic              en;
    logic [byte_w-1:0] idx;
    logic [word_w-1:0] data;
  } var_wr_t;

endpackage

//--- design/alu_unit.sv
module alu_unit (
  input  vm_pkg::alu_req_t          alu_req,
  output logic [vm_pkg::word_w-1:0] alu_result
);

  logic over_shift;

  // any count at or above the word width clears the result
  assign over_shift = |alu_req.b[vm_pkg::word_w-1:$clog2(vm_pkg::word_w)];

  always_comb begin
    case (alu_req.op)
      vm_pkg::pass_b: alu_result = alu_req.b;
      vm_pkg::add:    alu_result = alu_req.a + alu_req.b;
      vm_pkg::sub:    alu_result = alu_req.a - alu_req.b;
      vm_pkg::and_op: alu_result = alu_req.a & alu_req.b;
      vm_pkg::or_op:  alu_result = alu_req.a | alu_req.b;
      vm_pkg::shl: begin
        if (over_shift)
          alu_result = '0;
        else
          alu_result = alu_req.a << alu_req.b[$clog2(vm_pkg::word_w)-1:0];
      end
      vm_pkg::shr: begin
        if (over_shift)
          alu_result = '0;
        else
          alu_result = alu_req.a >> alu_req.b[$clog2(vm_pkg::word_w)-1:0];
      end
      // djnz counter step
      vm_pkg::dec:    alu_result = alu_req.a - 16'd1;
      default:        alu_result = alu_req.b;
    endcase
  end

endmodule

//--- design/branch_unit.sv
module branch_unit (
  input  vm_pkg::cmp_req_t cmp_req,
  output logic             taken
);

  logic [vm_pkg::word_w-1:0] dec_val;

  // djnz looks at the value it is about to write back
  assign dec_val = cmp_req.lhs - 16'd1;

  always_comb begin
    if (cmp_req.is_djnz) begin
      taken = (dec_val != '0);
    end else begin
      // all comparisons unsigned
      case (cmp_req.cond)
        vm_pkg::jz:  taken = (cmp_req.lhs == cmp_req.rhs);
        vm_pkg::jnz: taken = (cmp_req.lhs != cmp_req.rhs);
        vm_pkg::jg:  taken = (cmp_req.lhs >  cmp_req.rhs);
        vm_pkg::jge: taken = (cmp_req.lhs >= cmp_req.rhs);
        vm_pkg::jl:  taken = (cmp_req.lhs <  cmp_req.rhs);
        vm_pkg::jle: taken = (cmp_req.lhs <= cmp_req.rhs);
        default:     taken = 1'b0;
      endcase
    end
  end

endmodule

//--- design/var_file.sv
module var_file (
  input  logic                      clk,
  input  logic                      reset,
  input  logic [vm_pkg::byte_w-1:0] rd_idx_a,
  output logic [vm_pkg::word_w-1:0] rd_data_a,
  input  logic [vm_pkg::byte_w-1:0] rd_idx_b,
  output logic [vm_pkg::word_w-1:0] rd_data_b,
  input  vm_pkg::var_wr_t           var_wr,
  input  logic [vm_pkg::byte_w-1:0] host_idx,
  output logic [vm_pkg::word_w-1:0] host_data
);

  logic [vm_pkg::word_w-1:0] vars [vm_pkg::var_depth];

  // every variable starts at zero, later runs keep what earlier runs left
  always_ff @(posedge clk) begin
    if (!reset) begin
      for (int i = 0; i < vm_pkg::var_depth; i++)
        vars[i] <= '0;
    end else if (var_wr.en) begin
      vars[var_wr.idx] <= var_wr.data;
    end
  end

  // execution reads see the current contents in the same cycle
  assign rd_data_a = vars[rd_idx_a];
  assign rd_data_b = vars[rd_idx_b];

  // host side gets one cycle of latency
  always_ff @(posedge clk) begin
    host_data <= vars[host_idx];
  end

endmodule

//--- design/call_stack.sv
module call_stack (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      push,
  input  logic                      pop,
  input  logic [vm_pkg::word_w-1:0] push_data,
  output logic [vm_pkg::word_w-1:0] top
);

  logic [vm_pkg::word_w-1:0] entries [vm_pkg::stack_depth];
  logic [vm_pkg::byte_w-1:0] sp;
  logic [vm_pkg::byte_w-1:0] below;

  // pointer wraps at both ends
  always_ff @(posedge clk) begin
    if (!reset)
      sp <= '0;
    else if (push)
      sp <= sp + 8'd1;
    else if (pop)
      sp <= sp - 8'd1;
  end

  always_ff @(posedge clk) begin
    if (push)
      entries[sp] <= push_data;
  end

  // last pushed entry, ready before the pop edge
  assign below = sp - 8'd1;
  assign top   = entries[below];

endmodule

//--- design/code_ram.sv
module code_ram (
  input  logic                      clk,
  input  vm_pkg::prog_wr_t          prog_wr,
  input  logic [vm_pkg::word_w-1:0] fetch_addr,
  output logic [vm_pkg::byte_w-1:0] fetch_data
);

  logic [vm_pkg::byte_w-1:0] code [vm_pkg::code_depth];

  // host load port
  always_ff @(posedge clk) begin
    if (prog_wr.en)
      code[prog_wr.addr] <= prog_wr.data;
  end

  // upper pc bits alias onto the same 256 bytes
  assign fetch_data = code[fetch_addr[vm_pkg::byte_w-1:0]];

endmodule

//--- design/vm_sequencer.sv
module vm_sequencer (
  input  logic                      clk,
  input  logic                      reset,
  input  vm_pkg::run_cmd_t          run_cmd,
  output logic                      run_ack,
  output logic [vm_pkg::word_w-1:0] fetch_addr,
  input  logic [vm_pkg::byte_w-1:0] fetch_data,
  output vm_pkg::alu_req_t          alu_req,
  input  logic [vm_pkg::word_w-1:0] alu_result,
  output vm_pkg::cmp_req_t          cmp_req,
  input  logic                      taken,
  output logic [vm_pkg::byte_w-1:0] rd_idx_a,
  output logic [vm_pkg::byte_w-1:0] rd_idx_b,
  input  logic [vm_pkg::word_w-1:0] rd_data_a,
  input  logic [vm_pkg::word_w-1:0] rd_data_b,
  output vm_pkg::var_wr_t           var_wr,
  output logic                      push,
  output logic                      pop,
  output logic [vm_pkg::word_w-1:0] push_data,
  input  logic [vm_pkg::word_w-1:0] stack_top
);

  typedef enum logic [2:0] {st_idle, st_opcode, st_operand, st_execute, st_done} state_t;

  state_t                      state;
  logic [vm_pkg::word_w-1:0]   pc;
  logic [vm_pkg::byte_w-1:0]   opcode_r;
  logic [vm_pkg::byte_w-1:0]   subop;
  logic [6*vm_pkg::byte_w-1:0] ops;
  logic [2:0]                  op_cnt;
  logic [2:0]                  need;
  logic                        cj_wide;
  logic [vm_pkg::byte_w-1:0]   cj_src;
  logic [vm_pkg::byte_w-1:0]   dst_idx;
  logic [vm_pkg::word_w-1:0]   target;
  logic [vm_pkg::word_w-1:0]   next_pc;
  logic                        wr_en;

  // operand bytes following each opcode, unknown opcodes take none
  function automatic logic [2:0] op_bytes(input logic [7:0] op, input logic [7:0] sub);
    logic [2:0] n;
    case (op)
      vm_pkg::op_mov_const, vm_pkg::op_shl, vm_pkg::op_shr, vm_pkg::op_djnz: n = 3'd3;
      vm_pkg::op_mov, vm_pkg::op_add, vm_pkg::op_add_const, vm_pkg::op_sub,
      vm_pkg::op_and, vm_pkg::op_or, vm_pkg::op_jmp, vm_pkg::op_call: n = 3'd2;
      vm_pkg::op_cond_jmp: begin
        n = (sub[vm_pkg::subop_wide_bit] && !sub[vm_pkg::subop_var_bit]) ? 3'd6 : 3'd5;
      end
      default: n = 3'd0;
    endcase
    return n;
  endfunction

  // subop is stale while the first condJmp byte is read, harmless since need is 5 or 6
  assign need = op_bytes(opcode_r, subop);

  //////////////////////////////
  // state machine and pc
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (!reset) begin
      state   <= st_idle;
      pc      <= '0;
      op_cnt  <= '0;
      run_ack <= 1'b0;
    end else begin
      case (state)
        st_idle: begin
          if (run_cmd.req) begin
            pc    <= run_cmd.start_pc;
            state <= st_opcode;
          end
        end
        st_opcode: begin
          pc     <= pc + 16'd1;
          op_cnt <= '0;
          state  <= (op_bytes(fetch_data, subop) == 3'd0) ? st_execute : st_operand;
        end
        st_operand: begin
          pc     <= pc + 16'd1;
          op_cnt <= op_cnt + 3'd1;
          if (op_cnt + 3'd1 == need)
            state <= st_execute;
        end
        st_execute: begin
          pc <= next_pc;
          if (opcode_r == vm_pkg::op_kill_thread) begin
            run_ack <= 1'b1;
            state   <= st_done;
          end else begin
            state <= st_opcode;
          end
        end
        // hold the ack until the host lets go of req
        st_done: begin
          if (!run_cmd.req) begin
            run_ack <= 1'b0;
            state   <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == st_opcode)
      opcode_r <= fetch_data;
    if (state == st_operand) begin
      ops <= {ops[5*vm_pkg::byte_w-1:0], fetch_data};
      if (op_cnt == 3'd0)
        subop <= fetch_data;
    end
  end

  //////////////////////////////
  // operand field decode
  //////////////////////////////

  // bytes shift in at the bottom, so the last two are always the target
  assign target  = ops[15:0];
  assign cj_wide = subop[vm_pkg::subop_wide_bit] && !subop[vm_pkg::subop_var_bit];
  assign cj_src  = cj_wide ? ops[39:32] : ops[31:24];

  always_comb begin
    case (opcode_r)
      vm_pkg::op_mov_const, vm_pkg::op_shl, vm_pkg::op_shr, vm_pkg::op_djnz: begin
        dst_idx = ops[23:16];
      end
      default: dst_idx = ops[15:8];
    endcase
  end

  assign rd_idx_a = (opcode_r == vm_pkg::op_cond_jmp) ? cj_src : dst_idx;
  assign rd_idx_b = (opcode_r == vm_pkg::op_cond_jmp) ? ops[23:16] : ops[7:0];

  // data path requests
  always_comb begin
    alu_req.op = vm_pkg::pass_b;
    alu_req.a  = rd_data_a;
    alu_req.b  = rd_data_b;
    wr_en      = 1'b1;
    case (opcode_r)
      vm_pkg::op_mov_const: alu_req.b = ops[15:0];
      vm_pkg::op_mov:       alu_req.op = vm_pkg::pass_b;
      vm_pkg::op_add:       alu_req.op = vm_pkg::add;
      vm_pkg::op_add_const: begin
        alu_req.op = vm_pkg::add;
        alu_req.b  = {8'h00, ops[7:0]};
      end
      vm_pkg::op_sub:       alu_req.op = vm_pkg::sub;
      vm_pkg::op_and:       alu_req.op = vm_pkg::and_op;
      vm_pkg::op_or:        alu_req.op = vm_pkg::or_op;
      vm_pkg::op_shl: begin
        alu_req.op = vm_pkg::shl;
        alu_req.b  = ops[15:0];
      end
      vm_pkg::op_shr: begin
        alu_req.op = vm_pkg::shr;
        alu_req.b  = ops[15:0];
      end
      vm_pkg::op_djnz:      alu_req.op = vm_pkg::dec;
      default:              wr_en = 1'b0;
    endcase
  end

  assign var_wr.en   = (state == st_execute) && wr_en;
  assign var_wr.idx  = dst_idx;
  assign var_wr.data = alu_result;

  assign cmp_req.is_djnz = (opcode_r == vm_pkg::op_djnz);
  assign cmp_req.cond    = vm_pkg::cond_t'(subop[2:0]);
  assign cmp_req.lhs     = rd_data_a;
  assign cmp_req.rhs     = subop[vm_pkg::subop_var_bit] ? rd_data_b :
                           cj_wide ? ops[31:16] : {8'h00, ops[23:16]};

  // pc has already moved past the operands, which is also the return address
  always_comb begin
    case (opcode_r)
      vm_pkg::op_jmp, vm_pkg::op_call:     next_pc = target;
      vm_pkg::op_djnz, vm_pkg::op_cond_jmp: next_pc = taken ? target : pc;
      vm_pkg::op_ret:                       next_pc = stack_top;
      default:                              next_pc = pc;
    endcase
  end

  assign push       = (state == st_execute) && (opcode_r == vm_pkg::op_call);
  assign pop        = (state == st_execute) && (opcode_r == vm_pkg::op_ret);
  assign push_data  = pc;
  assign fetch_addr = pc;

endmodule

//--- design/vm_top.sv
module vm_top (
  input  logic                      clk,
  input  logic                      reset,
  input  vm_pkg::prog_wr_t          prog_wr,
  input  vm_pkg::run_cmd_t          run_cmd,
  output logic                      run_ack,
  input  logic [vm_pkg::byte_w-1:0] var_rd_idx,
  output logic [vm_pkg::word_w-1:0] var_rd_data
);

  logic [vm_pkg::word_w-1:0] fetch_addr;
  logic [vm_pkg::byte_w-1:0] fetch_data;
  vm_pkg::alu_req_t          alu_req;
  logic [vm_pkg::word_w-1:0] alu_result;
  vm_pkg::cmp_req_t          cmp_req;
  logic                      taken;
  logic [vm_pkg::byte_w-1:0] rd_idx_a;
  logic [vm_pkg::byte_w-1:0] rd_idx_b;
  logic [vm_pkg::word_w-1:0] rd_data_a;
  logic [vm_pkg::word_w-1:0] rd_data_b;
  vm_pkg::var_wr_t           var_wr;
  logic                      push;
  logic                      pop;
  logic [vm_pkg::word_w-1:0] push_data;
  logic [vm_pkg::word_w-1:0] stack_top;

  vm_sequencer i_seq (
    .clk, .reset, .run_cmd, .run_ack,
    .fetch_addr, .fetch_data,
    .alu_req, .alu_result,
    .cmp_req, .taken,
    .rd_idx_a, .rd_idx_b, .rd_data_a, .rd_data_b,
    .var_wr,
    .push, .pop, .push_data, .stack_top
  );

  alu_unit i_alu (.alu_req, .alu_result);

  branch_unit i_branch (.cmp_req, .taken);

  var_file i_vars (
    .clk, .reset,
    .rd_idx_a, .rd_data_a, .rd_idx_b, .rd_data_b,
    .var_wr,
    .host_idx  (var_rd_idx),
    .host_data (var_rd_data)
  );

  call_stack i_stack (.clk, .reset, .push, .pop, .push_data, .top(stack_top));

  code_ram i_code (.clk, .prog_wr, .fetch_addr, .fetch_data);

endmodule

//--- test/tb_clock.sv
module tb_clock (
  output logic clk,
  output logic reset
);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // active low, released after the third rising edge
  initial begin
    reset = 1'b0;
    repeat (3) @(posedge clk);
    reset <= 1'b1;
  end

endmodule

//--- test/vm_asserts.sv
module vm_asserts (
  input logic             clk,
  input logic             reset,
  input vm_pkg::prog_wr_t prog_wr,
  input vm_pkg::run_cmd_t run_cmd,
  input logic             run_ack
);

  // ack answers a live request only
  ack_rise_with_req: assert property (
    @(posedge clk) disable iff (!reset) $rose(run_ack) |-> run_cmd.req
  ) else $error("run_ack rose while run_cmd.req was low");

  ack_fall_after_req: assert property (
    @(posedge clk) disable iff (!reset) $fell(run_ack) |-> !$past(run_cmd.req)
  ) else $error("run_ack fell while run_cmd.req was still high");

  start_pc_stable: assert property (
    @(posedge clk) disable iff (!reset)
      run_cmd.req && $past(run_cmd.req) |-> $stable(run_cmd.start_pc)
  ) else $error("run_cmd.start_pc changed while req was high");

  // code loads belong to the idle phase
  code_write_idle: assert property (
    @(posedge clk) disable iff (!reset) prog_wr.en |-> !run_cmd.req && !run_ack
  ) else $error("code write during an active run handshake");

endmodule

bind vm_top vm_asserts i_asserts (
  .clk(clk), .reset(reset), .prog_wr(prog_wr), .run_cmd(run_cmd), .run_ack(run_ack)
);

//--- test/tb_top.sv
module tb_top;

  localparam int max_wait = 2000;

  logic                      clk;
  logic                      reset;
  vm_pkg::prog_wr_t          prog_wr;
  vm_pkg::run_cmd_t          run_cmd;
  logic                      run_ack;
  logic [vm_pkg::byte_w-1:0] var_rd_idx;
  logic [vm_pkg::word_w-1:0] var_rd_data;

  logic [31:0] rng_state;
  logic [7:0]  code_q [$];
  int          error_count;
  int          check_count;
  int          test_count;
  int          errors_at_start;

  tb_clock i_clock (.clk, .reset);

  vm_top i_dut (
    .clk, .reset, .prog_wr, .run_cmd, .run_ack, .var_rd_idx, .var_rd_data
  );

  //////////////////////////////
  // stimulus helpers
  //////////////////////////////

  function automatic logic [15:0] next_random();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state[15:0];
  endfunction

  // unsigned condJmp rule where codes 6 and 7 never branch
  function automatic logic expect_taken(input int cond, input logic [15:0] l,
                                        input logic [15:0] r);
    case (cond)
      0: return l == r;
      1: return l != r;
      2: return l > r;
      3: return l >= r;
      4: return l < r;
      5: return l <= r;
      default: return 1'b0;
    endcase
  endfunction

  function automatic void emit(input logic [7:0] b);
    code_q.push_back(b);
  endfunction

  function automatic void emit_pair(input logic [7:0] op, input logic [7:0] a,
                                    input logic [7:0] b);
    emit(op);
    emit(a);
    emit(b);
  endfunction

  // 16-bit fields go high byte first
  function automatic void emit_word(input logic [7:0] op, input logic [7:0] dst,
                                    input logic [15:0] w);
    emit(op);
    emit(dst);
    emit(w[15:8]);
    emit(w[7:0]);
  endfunction

  function automatic void emit_cond(input logic [7:0] subop, input logic [7:0] src,
                                    input logic [15:0] operand, input logic [15:0] target);
    emit(vm_pkg::op_cond_jmp);
    emit(subop);
    emit(src);
    if (subop[vm_pkg::subop_var_bit] || !subop[vm_pkg::subop_wide_bit]) begin
      emit(operand[7:0]);
    end else begin
      emit(operand[15:8]);
      emit(operand[7:0]);
    end
    emit(target[15:8]);
    emit(target[7:0]);
  endfunction

  // marker k copies the step counter in var 52 into var 60+k
  function automatic void emit_marker(input int k);
    emit_pair(vm_pkg::op_add_const, 8'd52, 8'd1);
    emit_pair(vm_pkg::op_mov, 8'(60 + k), 8'd52);
  endfunction

  //////////////////////////////
  // host side tasks
  //////////////////////////////

  task automatic load_program(input logic [7:0] base);
    vm_pkg::prog_wr_t wr;
    for (int i = 0; i < code_q.size(); i++) begin
      wr.en   = 1'b1;
      wr.addr = base + i[7:0];
      wr.data = code_q[i];
      @(posedge clk);
      prog_wr <= wr;
    end
    @(posedge clk);
    prog_wr <= '0;
    code_q.delete();
  endtask

  task automatic check_var(input logic [7:0] idx, input logic [15:0] expected);
    logic [15:0] got;
    @(posedge clk);
    var_rd_idx <= idx;
    // one cycle of read latency on the host port
    @(posedge clk);
    @(negedge clk);
    got = var_rd_data;
    check_count++;
    if (got !== expected) begin
      $display("** Error at time %0t: var_rd_data (var[%0d]) expected %h, got %h",
               $time, idx, expected, got);
      error_count++;
    end
  endtask

  task automatic start_run(input logic [15:0] start_pc);
    int waited;
    @(posedge clk);
    run_cmd.req      <= 1'b1;
    run_cmd.start_pc <= start_pc;
    waited = 0;
    @(negedge clk);
    while (run_ack !== 1'b1 && waited < max_wait) begin
      @(negedge clk);
      waited++;
    end
    if (run_ack !== 1'b1) begin
      $display("timeout: run from pc %h gave no run_ack within %0d cycles", start_pc, max_wait);
      error_count++;
    end
  endtask

  task automatic end_run();
    int waited;
    @(posedge clk);
    run_cmd.req <= 1'b0;
    waited = 0;
    @(negedge clk);
    while (run_ack !== 1'b0 && waited < max_wait) begin
      @(negedge clk);
      waited++;
    end
    if (run_ack !== 1'b0) begin
      $display("timeout: run_ack stayed high after req was dropped");
      error_count++;
    end
  endtask

  task automatic finish_test(input string name);
    test_count++;
    $display("test %-13s done, %0d errors", name, error_count - errors_at_start);
  endtask

  //////////////////////////////
  // directed tests
  //////////////////////////////

  task automatic test_reset();
    logic [15:0] r;
    errors_at_start = error_count;
    check_count++;
    if (run_ack !== 1'b0) begin
      $display("** Error at time %0t: run_ack expected 0, got %b", $time, run_ack);
      error_count++;
    end
    repeat (8) begin
      r = next_random();
      check_var(r[7:0], 16'h0000);
    end
    finish_test("reset");
  endtask

  task automatic test_data_ops();
    logic [15:0] a;
    logic [15:0] b;
    logic [15:0] k;
    logic [15:0] s_small;
    logic [15:0] s_big;
    logic [15:0] s_wide;
    errors_at_start = error_count;
    a       = next_random();
    b       = next_random();
    k       = next_random() % 16'd256;
    s_small = next_random() % 16'd16;
    s_big   = 16'd16 + next_random() % 16'd16;
    s_wide  = next_random() | 16'h0100;
    emit_word(vm_pkg::op_mov_const, 8'd10, a);
    emit_word(vm_pkg::op_mov_const, 8'd11, b);
    // var 12 takes b and vars 13 to 21 start from a
    for (int i = 12; i <= 21; i++)
      emit_pair(vm_pkg::op_mov, 8'(i), (i == 12) ? 8'd11 : 8'd10);
    emit_pair(vm_pkg::op_add, 8'd13, 8'd11);
    emit_pair(vm_pkg::op_sub, 8'd14, 8'd11);
    emit_pair(vm_pkg::op_and, 8'd15, 8'd11);
    emit_pair(vm_pkg::op_or, 8'd16, 8'd11);
    emit_pair(vm_pkg::op_add_const, 8'd17, k[7:0]);
    emit_word(vm_pkg::op_shl, 8'd18, s_small);
    emit_word(vm_pkg::op_shr, 8'd19, s_small);
    emit_word(vm_pkg::op_shl, 8'd20, s_big);
    emit_word(vm_pkg::op_shr, 8'd21, s_wide);
    emit(vm_pkg::op_kill_thread);
    load_program(8'h00);
    start_run(16'h0000);
    end_run();
    check_var(8'd10, a);
    check_var(8'd11, b);
    check_var(8'd12, b);
    check_var(8'd13, a + b);
    check_var(8'd14, a - b);
    check_var(8'd15, a & b);
    check_var(8'd16, a | b);
    check_var(8'd17, a + k);
    check_var(8'd18, a << s_small);
    check_var(8'd19, a >> s_small);
    check_var(8'd20, 16'h0000);
    check_var(8'd21, 16'h0000);
    finish_test("data_ops");
  endtask

  task automatic test_djnz();
    logic [15:0] n;
    logic [15:0] k;
    errors_at_start = error_count;
    n = next_random() % 16'd20 + 16'd1;
    k = next_random() % 16'd255 + 16'd1;
    emit_word(vm_pkg::op_mov_const, 8'd30, n);
    emit_word(vm_pkg::op_mov_const, 8'd31, 16'h0000);
    // loop body starts at address 8
    emit_pair(vm_pkg::op_add_const, 8'd31, k[7:0]);
    emit_word(vm_pkg::op_djnz, 8'd30, 16'h0008);
    emit(vm_pkg::op_kill_thread);
    load_program(8'h00);
    start_run(16'h0000);
    end_run();
    check_var(8'd31, n * k);
    check_var(8'd30, 16'h0000);
    finish_test("djnz");
  endtask

  task automatic test_cond_jmp();
    logic [15:0] lhs;
    logic [15:0] rhs;
    logic [7:0]  subop;
    logic [15:0] target;
    errors_at_start = error_count;
    // form 0 compares with a variable, 1 with an imm16, 2 with an imm8
    for (int form = 0; form < 3; form++) begin
      for (int cond = 0; cond < 8; cond++) begin
        for (int trial = 0; trial < 2; trial++) begin
          rhs = next_random();
          lhs = next_random();
          if (form == 2) begin
            rhs = rhs % 16'd256;
            lhs = lhs % 16'd256;
          end
          if (trial == 1)
            lhs = rhs;
          subop      = (form == 0) ? 8'h80 : (form == 1) ? 8'h40 : 8'h00;
          subop[2:0] = cond[2:0];
          // taken path begins right after the first kill
          target     = (form == 1) ? 16'd20 : 16'd19;
          emit_word(vm_pkg::op_mov_const, 8'd40, lhs);
          emit_word(vm_pkg::op_mov_const, 8'd41, rhs);
          emit_cond(subop, 8'd40, (form == 0) ? 16'd41 : rhs, target);
          emit_word(vm_pkg::op_mov_const, 8'd42, 16'h00AA);
          emit(vm_pkg::op_kill_thread);
          emit_word(vm_pkg::op_mov_const, 8'd42, 16'h0055);
          emit(vm_pkg::op_kill_thread);
          load_program(8'h00);
          start_run(16'h0000);
          end_run();
          check_var(8'd42, expect_taken(cond, lhs, rhs) ? 16'h0055 : 16'h00AA);
        end
      end
    end
    finish_test("cond_jmp");
  endtask

  task automatic test_control_flow();
    errors_at_start = error_count;
    emit_word(vm_pkg::op_mov_const, 8'd52, 16'h0000);
    emit_word(vm_pkg::op_mov_const, 8'd67, 16'h0000);
    emit_marker(0);
    emit_pair(vm_pkg::op_call, 8'h00, 8'h40);
    emit_marker(1);
    // skip marker 7 at 26 and land on marker 2 at 32
    emit_pair(vm_pkg::op_jmp, 8'h00, 8'd32);
    emit_marker(7);
    emit_marker(2);
    emit(vm_pkg::op_kill_thread);
    load_program(8'h00);
    emit_marker(3);
    emit_pair(vm_pkg::op_call, 8'h00, 8'h60);
    emit_marker(4);
    emit(vm_pkg::op_ret);
    load_program(8'h40);
    emit_marker(5);
    emit(vm_pkg::op_ret);
    load_program(8'h60);
    start_run(16'h0000);
    end_run();
    check_var(8'd60, 16'd1);
    check_var(8'd63, 16'd2);
    check_var(8'd65, 16'd3);
    check_var(8'd64, 16'd4);
    check_var(8'd61, 16'd5);
    check_var(8'd62, 16'd6);
    check_var(8'd67, 16'd0);
    check_var(8'd52, 16'd6);
    finish_test("control_flow");
  endtask

  task automatic test_handshake();
    logic [15:0] v;
    logic [15:0] w;
    errors_at_start = error_count;
    v = next_random();
    w = next_random();
    // first program mixes unkept opcodes between real instructions
    emit_word(vm_pkg::op_mov_const, 8'd70, v);
    emit(8'h06);
    emit_pair(vm_pkg::op_add_const, 8'd70, 8'd3);
    emit(8'hC3);
    emit_word(vm_pkg::op_mov_const, 8'd71, w);
    emit(8'h1F);
    emit(vm_pkg::op_kill_thread);
    load_program(8'h00);
    emit_pair(vm_pkg::op_mov, 8'd72, 8'd70);
    emit_pair(vm_pkg::op_add, 8'd72, 8'd71);
    emit(vm_pkg::op_kill_thread);
    load_program(8'h80);
    start_run(16'h0000);
    repeat (5) begin
      @(negedge clk);
      check_count++;
      if (run_ack !== 1'b1) begin
        $display("** Error at time %0t: run_ack expected 1, got %b", $time, run_ack);
        error_count++;
      end
    end
    end_run();
    start_run(16'h0080);
    end_run();
    check_var(8'd70, v + 16'd3);
    check_var(8'd71, w);
    check_var(8'd72, v + 16'd3 + w);
    finish_test("handshake");
  endtask

  initial begin
    int waited;
    rng_state   = 32'd29595;
    error_count = 0;
    check_count = 0;
    test_count  = 0;
    prog_wr     = '0;
    run_cmd     = '0;
    var_rd_idx  = '0;
    waited      = 0;
    while (reset !== 1'b1 && waited < 20) begin
      @(negedge clk);
      waited++;
    end
    if (reset !== 1'b1) begin
      $display("reset was never released");
      error_count++;
    end
    test_reset();
    test_data_ops();
    test_djnz();
    test_cond_jmp();
    test_control_flow();
    test_handshake();
    $display("tests %0d, checks %0d, errors %0d", test_count, check_count, error_count);
    if (error_count == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

//--- tb.f
design/vm_pkg.sv
design/alu_unit.sv
design/branch_unit.sv
design/var_file.sv
design/call_stack.sv
design/code_ram.sv
design/vm_sequencer.sv
design/vm_top.sv
test/tb_clock.sv
test/vm_asserts.sv
test/tb_top.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_top
FILELIST  = tb.f
BUILD_DIR = obj_dir
LOG       = sim.log

SOURCES := $(shell cat $(FILELIST))
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Verification failed" $(LOG); then exit 1; fi
	@if ! grep -q "Verification passed" $(LOG); then exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
